// File: Bender.yml
package:
  name: noncomp_multifmt_slice

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/slice_pkg.sv
      - verilog/lane_pipe.sv
      - verilog/noncomp_lane.sv
      - verilog/slice_dispatch.sv
      - verilog/result_pack.sv
      - verilog/noncomp_multifmt_slice.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_noncomp_slice.sv

// File: sim.f
+incdir+verilog
verilog/slice_pkg.sv
verilog/lane_pipe.sv
verilog/noncomp_lane.sv
verilog/slice_dispatch.sv
verilog/result_pack.sv
verilog/noncomp_multifmt_slice.sv
tests/tb_clock_gen.sv
tests/tb_noncomp_slice.sv

// File: tests/tb_clock_gen.sv
/*
 * Free-running testbench clock, starts low.
 * PERIOD_NS should be even so both phases are equal.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: tests/tb_noncomp_slice.sv
/*
 * Table-driven testbench for the two-lane min/max and sign-injection slice.
 * Items are offered only in cycles where lane 0 takes them at the next edge,
 * so stalls with in_valid held against a low in_ready are not exercised.
 */

`timescale 1ns/1ns
`default_nettype none

`include "slice_defs.svh"

module tb_noncomp_slice;

  import slice_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 200;
  localparam variant_t    VAR_MIN = 3'd0;
  localparam variant_t    VAR_MAX = 3'd1;
  localparam variant_t    VAR_J   = 3'd0;
  localparam variant_t    VAR_JN  = 3'd1;
  localparam variant_t    VAR_JX  = 3'd2;
  localparam status_t     ST_NONE = 5'h00;
  localparam status_t     ST_NV   = 5'h10;

  logic       clk;
  logic       rst_n;
  data_t      operand_a;
  data_t      operand_b;
  operation_e op;
  variant_t   variant;
  fp_format_e fmt;
  logic       vectorial;
  logic       in_valid;
  logic       in_ready;
  data_t      result;
  status_t    status;
  logic       out_valid;
  logic       out_ready;
  logic       busy;

  int seed;
  int mismatches;
  int failures;

  // Stimulus table, one entry per row in each queue
  data_t      tab_a[$];
  data_t      tab_b[$];
  operation_e tab_op[$];
  variant_t   tab_var[$];
  fp_format_e tab_fmt[$];
  logic       tab_vec[$];
  data_t      tab_res[$];
  status_t    tab_st[$];

  // Scoreboard of accepted items, oldest first
  data_t   exp_res_q[$];
  status_t exp_st_q[$];
  int      exp_row_q[$];

  tb_clock_gen #(.PERIOD_NS(4)) i_clk_gen (.clk_o(clk));

  noncomp_multifmt_slice dut0 (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_i        (op),
    .variant_i   (variant),
    .fmt_i       (fmt),
    .vectorial_i (vectorial),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  task automatic add_row(input data_t a, input data_t b, input operation_e op_v,
                         input variant_t var_v, input fp_format_e fmt_v, input logic vec_v,
                         input data_t res_v, input status_t st_v);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_op.push_back(op_v);
    tab_var.push_back(var_v);
    tab_fmt.push_back(fmt_v);
    tab_vec.push_back(vec_v);
    tab_res.push_back(res_v);
    tab_st.push_back(st_v);
  endtask

  task automatic load_table();
    // ------------------------------
    // FP32 min/max
    // ------------------------------
    add_row(32'h3f800000, 32'h40000000, MINMAX, VAR_MIN, FP32, 1'b0, 32'h3f800000, ST_NONE);
    add_row(32'h3f800000, 32'h40000000, MINMAX, VAR_MAX, FP32, 1'b0, 32'h40000000, ST_NONE);
    add_row(32'hbf800000, 32'h3f000000, MINMAX, VAR_MIN, FP32, 1'b0, 32'hbf800000, ST_NONE);
    add_row(32'hc0400000, 32'hc0000000, MINMAX, VAR_MAX, FP32, 1'b0, 32'hc0000000, ST_NONE);
    add_row(32'hff800000, 32'hc0000000, MINMAX, VAR_MAX, FP32, 1'b0, 32'hc0000000, ST_NONE);
    // Signed zeros, -0 below +0
    add_row(32'h00000000, 32'h80000000, MINMAX, VAR_MIN, FP32, 1'b0, 32'h80000000, ST_NONE);
    add_row(32'h80000000, 32'h00000000, MINMAX, VAR_MAX, FP32, 1'b0, 32'h00000000, ST_NONE);
    // NaN operands
    add_row(32'h7fc00000, 32'h3f800000, MINMAX, VAR_MIN, FP32, 1'b0, 32'h3f800000, ST_NONE);
    add_row(32'h40000000, 32'h7fc12345, MINMAX, VAR_MAX, FP32, 1'b0, 32'h40000000, ST_NONE);
    add_row(32'h7fc00000, 32'hffc00000, MINMAX, VAR_MIN, FP32, 1'b0, 32'h7fc00000, ST_NONE);
    add_row(32'h7f800001, 32'h3f800000, MINMAX, VAR_MIN, FP32, 1'b0, 32'h3f800000, ST_NV);
    add_row(32'h7fa00000, 32'h7fc00000, MINMAX, VAR_MAX, FP32, 1'b0, 32'h7fc00000, ST_NV);
    // ------------------------------
    // FP16 min/max
    // ------------------------------
    add_row(32'h40003c00, 32'h3c004000, MINMAX, VAR_MIN, FP16, 1'b1, 32'h3c003c00, ST_NONE);
    add_row(32'h40003c00, 32'h3c004000, MINMAX, VAR_MAX, FP16, 1'b1, 32'h40004000, ST_NONE);
    add_row(32'h7c01bc00, 32'h38003800, MINMAX, VAR_MIN, FP16, 1'b1, 32'h3800bc00, ST_NV);
    add_row(32'h3c008000, 32'h7e007d00, MINMAX, VAR_MAX, FP16, 1'b1, 32'h3c008000, ST_NV);
    add_row(32'h7e000000, 32'h7c018000, MINMAX, VAR_MIN, FP16, 1'b1, 32'h7e008000, ST_NV);
    // Scalar FP16 is NaN-boxed, vector flag on FP32 has no effect
    add_row(32'h12343c00, 32'habcd4000, MINMAX, VAR_MIN, FP16, 1'b0, 32'hffff3c00, ST_NONE);
    add_row(32'h00007e00, 32'h0000bc00, MINMAX, VAR_MAX, FP16, 1'b0, 32'hffffbc00, ST_NONE);
    // Upper half 7d00 would raise NV if lane 1 ran on an FP32 item
    add_row(32'h7d000000, 32'h3f800000, MINMAX, VAR_MAX, FP32, 1'b1, 32'h7d000000, ST_NONE);
    // ------------------------------
    // Sign injection
    // ------------------------------
    add_row(32'h3f800000, 32'h80000000, SGNJ, VAR_J,  FP32, 1'b0, 32'hbf800000, ST_NONE);
    add_row(32'h3f800000, 32'h80000000, SGNJ, VAR_JN, FP32, 1'b0, 32'h3f800000, ST_NONE);
    add_row(32'hbf800000, 32'hc0000000, SGNJ, VAR_JX, FP32, 1'b0, 32'h3f800000, ST_NONE);
    add_row(32'h40490fdb, 32'h80000000, SGNJ, VAR_JX, FP32, 1'b0, 32'hc0490fdb, ST_NONE);
    add_row(32'h7fa00000, 32'h00000000, SGNJ, VAR_J,  FP32, 1'b0, 32'h7fa00000, ST_NONE);
    add_row(32'h3c00bc00, 32'h80000000, SGNJ, VAR_J,  FP16, 1'b1, 32'hbc003c00, ST_NONE);
    add_row(32'h3c004000, 32'h00008000, SGNJ, VAR_JN, FP16, 1'b1, 32'hbc004000, ST_NONE);
    add_row(32'hbc00c000, 32'hbc004000, SGNJ, VAR_JX, FP16, 1'b1, 32'h3c00c000, ST_NONE);
    add_row(32'h7c017c01, 32'h80000000, SGNJ, VAR_J,  FP16, 1'b1, 32'hfc017c01, ST_NONE);
    add_row(32'h55553800, 32'h00003c00, SGNJ, VAR_JN, FP16, 1'b0, 32'hffffb800, ST_NONE);
  endtask

  task automatic present_row(input int idx);
    operand_a = tab_a[idx];
    operand_b = tab_b[idx];
    op        = tab_op[idx];
    variant   = tab_var[idx];
    fmt       = tab_fmt[idx];
    vectorial = tab_vec[idx];
    in_valid  = 1'b1;
  endtask

  task automatic push_expected(input int idx);
    exp_res_q.push_back(tab_res[idx]);
    exp_st_q.push_back(tab_st[idx]);
    exp_row_q.push_back(idx);
  endtask

  task automatic clear_expected();
    exp_res_q.delete();
    exp_st_q.delete();
    exp_row_q.delete();
  endtask

  // Called at a rising edge where an item is taken downstream
  task automatic check_output();
    data_t   exp_r;
    status_t exp_s;
    int      row;
    if (exp_res_q.size() == 0) begin
      failures++;
      $display("Output taken at %0t with no item in flight", $time);
    end else begin
      exp_r = exp_res_q.pop_front();
      exp_s = exp_st_q.pop_front();
      row   = exp_row_q.pop_front();
      if (result !== exp_r) begin
        mismatches++;
        $display("MISMATCH result_o row %0d: got %h expected %h", row, result, exp_r);
      end
      if (status !== exp_s) begin
        mismatches++;
        $display("MISMATCH status_o row %0d: got %h expected %h", row, status, exp_s);
      end
    end
  endtask

  task automatic check_reset_state();
    @(posedge clk);
    if (out_valid !== 1'b0) begin
      mismatches++;
      $display("MISMATCH out_valid_o after reset: got %h expected 0", out_valid);
    end
    if (busy !== 1'b0) begin
      mismatches++;
      $display("MISMATCH busy_o after reset: got %h expected 0", busy);
    end
    if (in_ready !== 1'b1) begin
      mismatches++;
      $display("MISMATCH in_ready_o after reset: got %h expected 1", in_ready);
    end
  endtask

  task automatic check_latency();
    int cycles;
    bit seen;
    @(negedge clk);
    out_ready = 1'b1;
    present_row(1);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      seen = in_ready;
      cycles++;
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (!seen) begin
      failures++;
      $display("Timeout waiting for in_ready_o on the first item");
    end else begin
      push_expected(1);
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
        seen = out_valid;
      end
      if (!seen) begin
        failures++;
        $display("Timeout waiting for out_valid_o on the first item");
        clear_expected();
      end else begin
        if (cycles != `SLICE_PIPE_REGS) begin
          failures++;
          $display("out_valid_o rose %0d cycles after acceptance instead of %0d",
                   cycles, `SLICE_PIPE_REGS);
        end
        check_output();
      end
    end
  endtask

  task automatic run_table(input bit backpressure);
    int   next_row;
    int   taken;
    int   idle;
    int   rnd;
    bit   full_seen;
    bit   hold_pending;
    data_t held_result;
    logic exp_ready;
    logic exp_busy;
    next_row     = 0;
    taken        = 0;
    idle         = 0;
    full_seen    = 1'b0;
    hold_pending = 1'b0;
    held_result  = '0;
    while (taken < tab_a.size() && idle < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (backpressure) begin
        rnd       = $random(seed);
        out_ready = (rnd[1:0] != 2'b00);
      end else begin
        out_ready = 1'b1;
      end
      // Offer an item only when lane 0 is sure to take it at the next edge
      if (next_row < tab_a.size() && (out_ready || !out_valid)) begin
        present_row(next_row);
      end else begin
        in_valid = 1'b0;
      end
      @(posedge clk);
      // Two items in flight fill the lane
      exp_ready = (exp_res_q.size() < `SLICE_PIPE_REGS) || out_ready;
      if (in_ready !== exp_ready) begin
        mismatches++;
        $display("MISMATCH in_ready_o at %0t: got %h expected %h", $time, in_ready, exp_ready);
      end
      exp_busy = (exp_res_q.size() != 0);
      if (busy !== exp_busy) begin
        mismatches++;
        $display("MISMATCH busy_o at %0t: got %h expected %h", $time, busy, exp_busy);
      end
      if (exp_res_q.size() == `SLICE_PIPE_REGS && !out_ready) begin
        full_seen = 1'b1;
      end
      if (hold_pending) begin
        if (out_valid !== 1'b1) begin
          mismatches++;
          $display("MISMATCH out_valid_o under stall: got %h expected 1", out_valid);
        end else if (result !== held_result) begin
          mismatches++;
          $display("MISMATCH result_o under stall: got %h expected %h", result, held_result);
        end
      end
      hold_pending = out_valid && !out_ready;
      held_result  = result;
      if (out_valid && out_ready) begin
        check_output();
        taken++;
        idle = 0;
      end else begin
        idle++;
      end
      if (in_valid && in_ready) begin
        push_expected(next_row);
        next_row++;
      end
    end
    if (taken < tab_a.size()) begin
      failures++;
      $display("Timeout with only %0d of %0d items returned", taken, tab_a.size());
      clear_expected();
    end
    if (backpressure && !full_seen) begin
      failures++;
      $display("The pipeline never filled while out_ready_i was low");
    end
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    @(posedge clk);
    if (busy !== 1'b0) begin
      mismatches++;
      $display("MISMATCH busy_o after drain: got %h expected 0", busy);
    end
    if (out_valid !== 1'b0) begin
      mismatches++;
      $display("MISMATCH out_valid_o after drain: got %h expected 0", out_valid);
    end
  endtask

  initial begin
    seed       = 11820;
    mismatches = 0;
    failures   = 0;
    rst_n      = 1'b0;
    operand_a  = '0;
    operand_b  = '0;
    op         = MINMAX;
    variant    = '0;
    fmt        = FP32;
    vectorial  = 1'b0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    load_table();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    check_reset_state();
    check_latency();
    run_table(1'b0);
    run_table(1'b1);
    run_table(1'b1);

    $display("Done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lane_pipe.sv
/*
 * Elastic pipeline of DEPTH enable-registered stages, DEPTH >= 1.
 * Ready runs back through the chain so empty stages are filled without stalls.
 * data_o is undefined until the first item reaches the last stage.
 */

`timescale 1ns/1ns
`default_nettype none

module lane_pipe #(
  parameter int unsigned DEPTH     = 2,
  parameter int unsigned PAYLOAD_W = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [PAYLOAD_W-1:0] data_i,
  output logic [PAYLOAD_W-1:0] data_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  // Index 0 is the input, index i the state after i stages
  logic [DEPTH:0]                valid_q;
  logic [DEPTH:0]                ready;
  logic [DEPTH:0][PAYLOAD_W-1:0] data_q;

  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = data_i;

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    // Move on if the next stage drains or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  assign ready[DEPTH] = out_ready_i;
  assign in_ready_o   = ready[0];
  assign out_valid_o  = valid_q[DEPTH];
  assign data_o       = data_q[DEPTH];
  assign busy_o       = |valid_q[DEPTH:1];

  // A full chain that cannot drain keeps every item
  a_full_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !in_ready_o && !out_ready_i |=> &valid_q[DEPTH:1]);

endmodule

`default_nettype wire

// File: verilog/noncomp_lane.sv
/*
 * One lane: min/max and sign injection, then a lane_pipe.
 * With HAS_FP32 = 0 the lane handles FP16 only, in the low half of a_i/b_i.
 * FP16 results come out NaN-boxed in the upper half.
 */

`timescale 1ns/1ns
`default_nettype none

`include "slice_defs.svh"

module noncomp_lane #(
  parameter bit HAS_FP32 = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  slice_pkg::data_t      a_i,
  input  slice_pkg::data_t      b_i,
  input  slice_pkg::operation_e op_i,
  input  slice_pkg::variant_t   variant_i,
  input  slice_pkg::fp_format_e fmt_i,
  input  slice_pkg::aux_t       aux_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output slice_pkg::data_t      result_o,
  output slice_pkg::status_t    status_o,
  output slice_pkg::aux_t       aux_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  import slice_pkg::*;

  localparam int unsigned PAYLOAD_W = $bits(aux_t) + $bits(status_t) + `SLICE_WIDTH;

  // Returns {sign, nan, quiet bit, zero, magnitude}
  function automatic logic [34:0] unpack_op(input data_t v, input logic fp32);
    logic [34:0] r;
    if (fp32) begin
      r = {v[31], (&v[30:23]) & (|v[22:0]), v[22], ~|v[30:0], v[30:0]};
    end else begin
      r = {v[15], (&v[14:10]) & (|v[9:0]), v[9], ~|v[14:0], 16'b0, v[14:0]};
    end
    return r;
  endfunction

  logic        is_fp32;
  logic        sign_a, sign_b, nan_a, nan_b, quiet_a, quiet_b, zero_a, zero_b;
  logic [30:0] mag_a, mag_b;
  logic        snan_a, snan_b;
  logic        a_lt_b, sgn_new;
  data_t       canon_nan;
  data_t       res_d;
  status_t     stat_d;
  logic [PAYLOAD_W-1:0] pipe_in, pipe_out;

  assign is_fp32 = HAS_FP32 && (fmt_i == FP32);

  assign {sign_a, nan_a, quiet_a, zero_a, mag_a} = unpack_op(a_i, is_fp32);
  assign {sign_b, nan_b, quiet_b, zero_b, mag_b} = unpack_op(b_i, is_fp32);
  assign snan_a = nan_a & ~quiet_a;
  assign snan_b = nan_b & ~quiet_b;

  assign canon_nan = is_fp32 ? `QNAN_FP32 : {16'hffff, `QNAN_FP16};

  // ------------------------------
  // Ordering and sign selection
  // ------------------------------
  always_comb begin : order
    if (zero_a && zero_b) begin
      // -0 orders below +0
      a_lt_b = sign_a & ~sign_b;
    end else if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : sign_sel
    case (variant_i)
      3'd1:    sgn_new = ~sign_b;
      3'd2:    sgn_new = sign_a ^ sign_b;
      default: sgn_new = sign_b;
    endcase
  end

  always_comb begin : compute
    res_d  = a_i;
    stat_d = '0;
    if (op_i == MINMAX) begin
      stat_d[4] = snan_a | snan_b;
      if (nan_a && nan_b) begin
        res_d = canon_nan;
      end else if (nan_a) begin
        res_d = b_i;
      end else if (nan_b) begin
        res_d = a_i;
      end else if (variant_i == 3'd1) begin
        res_d = a_lt_b ? b_i : a_i;
      end else begin
        res_d = a_lt_b ? a_i : b_i;
      end
    end else if (is_fp32) begin
      res_d = {sgn_new, a_i[30:0]};
    end else begin
      res_d[15] = sgn_new;
    end
    // NaN-box narrow results
    if (!is_fp32) begin
      res_d[31:16] = 16'hffff;
    end
  end

  // ------------------------------
  // Lane pipeline
  // ------------------------------
  assign pipe_in = {aux_i, stat_d, res_d};

  lane_pipe #(
    .DEPTH     (`SLICE_PIPE_REGS),
    .PAYLOAD_W (PAYLOAD_W)
  ) i_lane_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .data_i      (pipe_in),
    .data_o      (pipe_out),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  assign {aux_o, status_o, result_o} = pipe_out;

  // A presented result stays until downstream takes it
  a_hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o));

endmodule

`default_nettype wire

// File: verilog/noncomp_multifmt_slice.sv
/*
 * Two-lane min/max and sign-injection slice for FP32 and FP16.
 * Lane 0 owns both handshakes; lane 1 follows it for vector FP16 requests.
 */

`timescale 1ns/1ns
`default_nettype none

module noncomp_multifmt_slice (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  slice_pkg::data_t      operand_a_i,
  input  slice_pkg::data_t      operand_b_i,
  input  slice_pkg::operation_e op_i,
  input  slice_pkg::variant_t   variant_i,
  input  slice_pkg::fp_format_e fmt_i,
  input  logic                  vectorial_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output slice_pkg::data_t      result_o,
  output slice_pkg::status_t    status_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  import slice_pkg::*;

  data_t      lane0_a, lane0_b;
  half_t      lane1_a, lane1_b;
  logic [1:0] lane_valid;
  aux_t       aux;
  logic       lane0_ready;
  data_t      lane0_result, lane1_result;
  status_t    lane0_status, lane1_status;
  aux_t       lane0_aux;
  logic       lane1_out_valid;
  logic [1:0] lane_busy;

  slice_dispatch i_dispatch (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .fmt_i        (fmt_i),
    .vectorial_i  (vectorial_i),
    .in_valid_i   (in_valid_i),
    .lane_ready_i (lane0_ready),
    .lane0_a_o    (lane0_a),
    .lane0_b_o    (lane0_b),
    .lane1_a_o    (lane1_a),
    .lane1_b_o    (lane1_b),
    .lane_valid_o (lane_valid),
    .aux_o        (aux),
    .in_ready_o   (in_ready_o)
  );

  noncomp_lane #(.HAS_FP32(1'b1)) i_lane0 (
    .clk_i, .rst_n_i,
    .a_i         (lane0_a),
    .b_i         (lane0_b),
    .op_i, .variant_i, .fmt_i,
    .aux_i       (aux),
    .in_valid_i  (lane_valid[0]),
    .in_ready_o  (lane0_ready),
    .result_o    (lane0_result),
    .status_o    (lane0_status),
    .aux_o       (lane0_aux),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (lane_busy[0])
  );

  // Upper lane drains only when the head item is a vector
  noncomp_lane #(.HAS_FP32(1'b0)) i_lane1 (
    .clk_i, .rst_n_i,
    .a_i         ({16'hffff, lane1_a}),
    .b_i         ({16'hffff, lane1_b}),
    .op_i, .variant_i, .fmt_i,
    .aux_i       (aux),
    .in_valid_i  (lane_valid[1]),
    .in_ready_o  (),
    .result_o    (lane1_result),
    .status_o    (lane1_status),
    .aux_o       (),
    .out_valid_o (lane1_out_valid),
    .out_ready_i (out_ready_i & lane0_aux[1]),
    .busy_o      (lane_busy[1])
  );

  result_pack i_pack (
    .lane0_result_i (lane0_result),
    .lane1_result_i (lane1_result),
    .lane0_status_i (lane0_status),
    .lane1_status_i (lane1_status),
    .lane1_valid_i  (lane1_out_valid),
    .aux_i          (lane0_aux),
    .result_o       (result_o),
    .status_o       (status_o)
  );

  assign busy_o = |lane_busy;

endmodule

`default_nettype wire

// File: verilog/result_pack.sv
/*
 * Output packing by format. Combinational.
 * Lane 1 contributes only to vector FP16 results; otherwise the upper
 * half is NaN-boxed with ones for FP16.
 */

`timescale 1ns/1ns
`default_nettype none

module result_pack (
  input  slice_pkg::data_t   lane0_result_i,
  input  slice_pkg::data_t   lane1_result_i,
  input  slice_pkg::status_t lane0_status_i,
  input  slice_pkg::status_t lane1_status_i,
  input  logic               lane1_valid_i,
  input  slice_pkg::aux_t    aux_i,
  output slice_pkg::data_t   result_o,
  output slice_pkg::status_t status_o
);

  import slice_pkg::*;

  logic       is_vector;
  fp_format_e res_fmt;
  logic       lane1_used;
  half_t      upper_half;
  status_t    lane1_status;

  assign is_vector = aux_i[1];
  assign res_fmt   = fp_format_e'(aux_i[0]);

  // Upper lane counts only while it holds the matching vector item
  assign lane1_used = is_vector & lane1_valid_i;

  assign upper_half   = lane1_used ? lane1_result_i[15:0] : 16'hffff;
  assign lane1_status = lane1_used ? lane1_status_i : '0;

  // ------------------------------
  // Packing
  // ------------------------------
  always_comb begin : pack
    if (res_fmt == FP32) begin
      result_o = lane0_result_i;
    end else begin
      result_o = {upper_half, lane0_result_i[15:0]};
    end
  end

  // Lane flags merge into one status word
  assign status_o = lane0_status_i | lane1_status;

endmodule

`default_nettype wire

// File: verilog/slice_defs.svh
/*
 * Datapath width and lane depth for the non-computational FP slice.
 * Only FP32 and FP16 are supported, so the width must stay at 32.
 */

`ifndef SLICE_DEFS_SVH
`define SLICE_DEFS_SVH

// Full operand and result width
`define SLICE_WIDTH 32

// Register stages per lane, also the lane capacity in items
`define SLICE_PIPE_REGS 2

// Canonical quiet NaNs
`define QNAN_FP32 32'h7fc00000
`define QNAN_FP16 16'h7e00

`endif

// File: verilog/slice_dispatch.sv
/*
 * Input side of the slice. Purely combinational.
 * Vector mode applies to FP16 only; FP32 always runs scalar in lane 0.
 */

`timescale 1ns/1ns
`default_nettype none

`include "slice_defs.svh"

module slice_dispatch (
  input  slice_pkg::data_t      operand_a_i,
  input  slice_pkg::data_t      operand_b_i,
  input  slice_pkg::fp_format_e fmt_i,
  input  logic                  vectorial_i,
  input  logic                  in_valid_i,
  input  logic                  lane_ready_i,
  output slice_pkg::data_t      lane0_a_o,
  output slice_pkg::data_t      lane0_b_o,
  output slice_pkg::half_t      lane1_a_o,
  output slice_pkg::half_t      lane1_b_o,
  output logic [1:0]            lane_valid_o,
  output slice_pkg::aux_t       aux_o,
  output logic                  in_ready_o
);

  import slice_pkg::*;

  logic vec_op;

  // An FP32 request never splits across lanes
  assign vec_op = vectorial_i & (fmt_i == FP16);

  // Lane 0 sees the whole word and uses the low half for FP16
  assign lane0_a_o = operand_a_i;
  assign lane0_b_o = operand_b_i;
  assign lane1_a_o = operand_a_i[`SLICE_WIDTH-1:`SLICE_WIDTH/2];
  assign lane1_b_o = operand_b_i[`SLICE_WIDTH-1:`SLICE_WIDTH/2];

  // Upper lane only takes part in vector requests
  assign lane_valid_o = {in_valid_i & vec_op, in_valid_i};

  assign aux_o = {vec_op, fmt_i};

  // Lane 0 alone answers upstream
  assign in_ready_o = lane_ready_i;

endmodule

`default_nettype wire

// File: verilog/slice_pkg.sv
/*
 * Shared types of the FP32/FP16 min/max and sign-injection slice.
 * Status flags follow the RISC-V fflags order.
 */

`default_nettype none

`include "slice_defs.svh"

package slice_pkg;

  // Operand and result words
  typedef logic [`SLICE_WIDTH-1:0]   data_t;
  typedef logic [`SLICE_WIDTH/2-1:0] half_t;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // MINMAX: 0 min, 1 max
  // SGNJ: 0 J, 1 JN, 2 JX
  typedef logic [2:0] variant_t;

  // Flags NV, DZ, OF, UF, NX from msb down
  typedef logic [4:0] status_t;

  // Bit 1 is the effective vector flag, bit 0 the format
  typedef logic [1:0] aux_t;

endpackage

`default_nettype wire
